/* memTagStage_settings.svh */
//**********************************************************
// Memory tag-access stage settings
// Widths, line geometry, legal address limit and the
// refill latency of the miss path
//**********************************************************

`ifndef MEMTAG_STAGE_SETTINGS_SVH
`define MEMTAG_STAGE_SETTINGS_SVH

// Byte address and order tag widths
`define MEMTAG_ADDR_WIDTH 32
`define MEMTAG_TAG_WIDTH 6

// Cache line size in bytes
`define MEMTAG_LINE_BYTES 16

// First byte address that may not be accessed
`define MEMTAG_LEGAL_LIMIT 32'h8000_0000

// Refill time from MSHR allocation, in unstalled cycles
`define MEMTAG_FILL_LATENCY 6
`define MEMTAG_FILL_CNT_WIDTH 3

`endif

/* memTagPkg.sv */
//**********************************************************
// Memory tag-access stage types
// Operation, environment, size, result and MSHR encodings
//**********************************************************

`default_nettype none

`include "memTagStage_settings.svh"

package memTagPkg;

    localparam int LineOffsetBits = $clog2(`MEMTAG_LINE_BYTES);
    localparam int LineWidth = `MEMTAG_ADDR_WIDTH - LineOffsetBits;

    typedef logic [`MEMTAG_ADDR_WIDTH-1:0] MemAddr;
    typedef logic [LineWidth-1:0] LineAddr;
    typedef logic [`MEMTAG_TAG_WIDTH-1:0] OpTag;

    typedef enum logic [1:0] {OpLoad, OpStore, OpEnv, OpFenceI} MemOpType;

    typedef enum logic [1:0] {EnvBreak, EnvCall, EnvMret, EnvIllegal} EnvCode;

    typedef enum logic [1:0] {SizeByte, SizeHalf, SizeWord} AccessSize;

    // Outcome handed to the commit logic
    typedef enum logic [3:0] {
        ExecNone,
        ExecSuccess,
        ExecRefetchThis,
        ExecRefetchNext,
        ExecTrapBreak,
        ExecTrapCall,
        ExecTrapMret,
        ExecFaultIllegalInsn,
        ExecFaultLoadMisaligned,
        ExecFaultLoadViolation,
        ExecFaultStoreMisaligned,
        ExecFaultStoreViolation
    } ExecState;

    typedef enum logic [1:0] {MshrIdle, MshrWaitFill, MshrFilled} MshrState;

endpackage

`default_nettype wire

/* memTagOpIf.sv */
//**********************************************************
// Registered memory operation bundle
// Carries the issued op and its lookup flags to the resolver
//**********************************************************

`timescale 1ns/100ps
`default_nettype none

interface memTagOpIf;
    import memTagPkg::*;

    logic      valid;
    MemOpType  opType;
    EnvCode    envCode;
    AccessSize size;
    MemAddr    addr;
    OpTag      tag;
    logic      dcHit;
    logic      forwarded;
    logic      forwardMiss;
    logic      conflict;

    modport pipe (output valid, opType, envCode, size, addr, tag,
                  dcHit, forwarded, forwardMiss, conflict);

    modport resolve (input valid, opType, envCode, size, addr, tag,
                     dcHit, forwarded, forwardMiss, conflict);

endinterface

`default_nettype wire

/* memTagPipeReg.sv */
//**********************************************************
// Issue pipeline register
// Captures the issued op and its lookup flags when unstalled
//**********************************************************

`timescale 1ns/100ps
`default_nettype none

module memTagPipeReg (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 stall,
    input  logic                 issueValid,
    input  memTagPkg::MemOpType  issueOpType,
    input  memTagPkg::EnvCode    issueEnvCode,
    input  memTagPkg::AccessSize issueSize,
    input  memTagPkg::MemAddr    issueAddr,
    input  memTagPkg::OpTag      issueTag,
    input  logic                 dcHit,
    input  logic                 forwarded,
    input  logic                 forwardMiss,
    input  logic                 conflict,
    memTagOpIf.pipe              op
);
    import memTagPkg::*;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            op.valid <= 1'b0;
        end else if (!stall) begin
            op.valid <= issueValid;
        end
    end

    // Payload follows valid but needs no clear
    always_ff @(posedge clk) begin
        if (!stall) begin
            op.opType      <= issueOpType;
            op.envCode     <= issueEnvCode;
            op.size        <= issueSize;
            op.addr        <= issueAddr;
            op.tag         <= issueTag;
            op.dcHit       <= dcHit;
            op.forwarded   <= forwarded;
            op.forwardMiss <= forwardMiss;
            op.conflict    <= conflict;
        end
    end

endmodule

`default_nettype wire

/* memTagFillTimer.sv */
//**********************************************************
// Line fill timer
// Counts the refill latency and pulses when the line is in
//**********************************************************

`timescale 1ns/100ps
`default_nettype none

`include "memTagStage_settings.svh"

module memTagFillTimer (
    input  logic clk,
    input  logic arstN,
    input  logic stall,
    input  logic start,
    output logic fillDone
);
    logic                              busy;
    logic [`MEMTAG_FILL_CNT_WIDTH-1:0] count;

    // Last count value falls in the cycle before the FSM turns filled
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= `MEMTAG_FILL_CNT_WIDTH'(`MEMTAG_FILL_LATENCY - 1);
        end else if (busy && !stall) begin
            if (count == '0) begin
                busy <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // Frozen while the pipe is stalled
    assign fillDone = busy && !stall && (count == '0);

endmodule

`default_nettype wire

/* memTagMissFsm.sv */
//**********************************************************
// Single-entry MSHR
// Allocates on a load miss, waits for the refill and frees
// the line once a load has read it
//**********************************************************

`timescale 1ns/100ps
`default_nettype none

module memTagMissFsm (
    input  logic                clk,
    input  logic                arstN,
    input  logic                stall,
    input  logic                allocate,
    input  memTagPkg::LineAddr  missLine,
    input  logic                releaseLine,
    output memTagPkg::MshrState mshrState,
    output memTagPkg::LineAddr  mshrLine,
    output logic                fillReq,
    output memTagPkg::LineAddr  fillLine
);
    import memTagPkg::*;

    MshrState state;
    LineAddr  lineQ;
    logic     fillReqQ;
    logic     start;
    logic     fillDone;

    assign start = allocate && (state == MshrIdle);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= MshrIdle;
        end else begin
            case (state)
                MshrIdle:     if (allocate) state <= MshrWaitFill;
                MshrWaitFill: if (fillDone) state <= MshrFilled;
                MshrFilled:   if (releaseLine) state <= MshrIdle;
                default:      state <= MshrIdle;
            endcase
        end
    end

    // Request lines up with the allocating load's result
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fillReqQ <= 1'b0;
        end else if (!stall) begin
            fillReqQ <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            lineQ <= missLine;
        end
    end

    memTagFillTimer i_fillTimer (
        .clk      (clk),
        .arstN    (arstN),
        .stall    (stall),
        .start    (start),
        .fillDone (fillDone)
    );

    assign mshrState = state;
    assign mshrLine  = lineQ;
    assign fillReq   = fillReqQ && !stall;
    assign fillLine  = lineQ;

endmodule

`default_nettype wire

/* memTagResolve.sv */
//**********************************************************
// Tag-access resolver
// Turns hit, forward and conflict flags into an exec state,
// checks faults and drives the MSHR and replay controls
//**********************************************************

`timescale 1ns/100ps
`default_nettype none

`include "memTagStage_settings.svh"

module memTagResolve (
    input  logic                clk,
    input  logic                arstN,
    input  logic                stall,
    input  logic                flushAll,
    memTagOpIf.resolve          op,
    input  memTagPkg::MshrState mshrState,
    input  memTagPkg::LineAddr  mshrLine,
    output logic                allocate,
    output memTagPkg::LineAddr  missLine,
    output logic                releaseLine,
    output logic                resultValid,
    output memTagPkg::ExecState resultState,
    output memTagPkg::OpTag     resultTag,
    output logic                replayValid,
    output logic                replayMshr,
    output logic                orderViolation
);
    import memTagPkg::*;

    logic     update, isLoad, isStore;
    logic     illegalAddr, misaligned, mshrHit;
    logic     missReq, allocReq, releaseReq, violationReq;
    LineAddr  lineAddr;
    ExecState nextState;
    logic     validQ, replayQ, replayMshrQ, violationQ;
    ExecState stateQ;
    OpTag     tagQ;

    // A flushed op leaves no trace in the MSHR or the replay path
    assign update   = op.valid && !stall && !flushAll;
    assign isLoad   = (op.opType == OpLoad);
    assign isStore  = (op.opType == OpStore);
    assign lineAddr = op.addr[`MEMTAG_ADDR_WIDTH-1:LineOffsetBits];
    assign mshrHit  = (mshrState == MshrFilled) && (mshrLine == lineAddr);

    assign illegalAddr = (op.addr >= `MEMTAG_LEGAL_LIMIT);

    always_comb begin
        case (op.size)
            SizeHalf: misaligned = op.addr[0];
            SizeWord: misaligned = |op.addr[1:0];
            default:  misaligned = 1'b0;
        endcase
    end

    always_comb begin
        nextState    = ExecNone;
        missReq      = 1'b0;
        allocReq     = 1'b0;
        releaseReq   = 1'b0;
        violationReq = 1'b0;
        if (op.valid) begin
            case (op.opType)
                OpLoad: begin
                    if (op.forwarded) begin
                        nextState = op.forwardMiss ? ExecRefetchThis : ExecSuccess;
                    end else if (mshrHit) begin
                        nextState  = ExecSuccess;
                        releaseReq = 1'b1;
                    end else if (op.dcHit) begin
                        nextState = ExecSuccess;
                    end else begin
                        // Miss is replayed, MSHR taken only if free
                        nextState = ExecRefetchThis;
                        missReq   = 1'b1;
                        allocReq  = (mshrState == MshrIdle);
                    end
                end
                OpStore: begin
                    nextState    = op.conflict ? ExecRefetchNext : ExecSuccess;
                    violationReq = op.conflict;
                end
                OpEnv: begin
                    case (op.envCode)
                        EnvBreak: nextState = ExecTrapBreak;
                        EnvCall:  nextState = ExecTrapCall;
                        EnvMret:  nextState = ExecTrapMret;
                        default:  nextState = ExecFaultIllegalInsn;
                    endcase
                end
                default: nextState = ExecRefetchNext;
            endcase
            // Violation wins over misalignment
            if ((isLoad || isStore) && (nextState inside {ExecSuccess, ExecRefetchNext})) begin
                if (illegalAddr) begin
                    nextState = isLoad ? ExecFaultLoadViolation : ExecFaultStoreViolation;
                end else if (misaligned) begin
                    nextState = isLoad ? ExecFaultLoadMisaligned : ExecFaultStoreMisaligned;
                end
            end
        end
    end

    assign allocate    = update && allocReq;
    assign releaseLine = update && releaseReq;
    assign missLine    = lineAddr;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ      <= 1'b0;
            replayQ     <= 1'b0;
            replayMshrQ <= 1'b0;
            violationQ  <= 1'b0;
        end else if (!stall) begin
            validQ      <= op.valid && !flushAll;
            replayQ     <= update && missReq;
            replayMshrQ <= allocate;
            violationQ  <= update && violationReq;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            stateQ <= nextState;
            tagQ   <= op.tag;
        end
    end

    // Held result shows only in the first unstalled cycle
    assign resultValid    = validQ && !stall;
    assign resultState    = stateQ;
    assign resultTag      = tagQ;
    assign replayValid    = replayQ && !stall;
    assign replayMshr     = replayMshrQ && !stall;
    assign orderViolation = violationQ && !stall;

endmodule

`default_nettype wire

/* memTagStage.sv */
//**********************************************************
// Memory tag-access stage top level
// Pipeline register, resolver and single MSHR
//**********************************************************

`timescale 1ns/100ps
`default_nettype none

module memTagStage (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 stall,
    input  logic                 flushAll,
    input  logic                 issueValid,
    input  memTagPkg::MemOpType  issueOpType,
    input  memTagPkg::EnvCode    issueEnvCode,
    input  memTagPkg::AccessSize issueSize,
    input  memTagPkg::MemAddr    issueAddr,
    input  memTagPkg::OpTag      issueTag,
    input  logic                 dcHit,
    input  logic                 forwarded,
    input  logic                 forwardMiss,
    input  logic                 conflict,
    output logic                 resultValid,
    output memTagPkg::ExecState  resultState,
    output memTagPkg::OpTag      resultTag,
    output logic                 replayValid,
    output logic                 replayMshr,
    output logic                 orderViolation,
    output logic                 fillReq,
    output memTagPkg::LineAddr   fillLine
);
    import memTagPkg::*;

    logic     allocate;
    logic     releaseLine;
    LineAddr  missLine;
    LineAddr  mshrLine;
    MshrState mshrState;

    memTagOpIf opBus ();

    memTagPipeReg i_pipeReg (
        .clk, .arstN, .stall, .issueValid, .issueOpType, .issueEnvCode,
        .issueSize, .issueAddr, .issueTag, .dcHit, .forwarded,
        .forwardMiss, .conflict,
        .op (opBus.pipe)
    );

    memTagResolve i_resolve (
        .clk, .arstN, .stall, .flushAll,
        .op (opBus.resolve),
        .mshrState, .mshrLine, .allocate, .missLine, .releaseLine,
        .resultValid, .resultState, .resultTag, .replayValid,
        .replayMshr, .orderViolation
    );

    // Fill request leaves the stage directly from the MSHR
    memTagMissFsm i_missFsm (
        .clk, .arstN, .stall, .allocate, .missLine, .releaseLine,
        .mshrState, .mshrLine, .fillReq, .fillLine
    );

endmodule

`default_nettype wire

/* tbMemTagChecker.sv */
//**********************************************************
// Result checker for the tag-access stage testbench
// Matches every result against the next unflushed entry
//**********************************************************

`timescale 1ns/100ps
`default_nettype none

module tbMemTagChecker #(
    parameter int Depth = 64
) (
    input  logic                clk,
    input  logic                arstN,
    input  logic                resultValid,
    input  memTagPkg::ExecState resultState,
    input  memTagPkg::OpTag     resultTag,
    input  logic                replayValid,
    input  logic                replayMshr,
    input  logic                orderViolation,
    input  logic                fillReq,
    input  memTagPkg::LineAddr  fillLine,
    input  int                  numEntries,
    input  logic                expResult [Depth],
    input  memTagPkg::ExecState expState [Depth],
    input  logic [3:0]          expFlags [Depth],
    input  memTagPkg::LineAddr  expLine [Depth],
    output int                  valueErrors,
    output int                  seqErrors,
    output int                  resultCount
);
    import memTagPkg::*;

    int nextIdx = 0;
    int valueCount = 0;
    int seqCount = 0;
    int seenCount = 0;

    assign valueErrors = valueCount;
    assign seqErrors   = seqCount;
    assign resultCount = seenCount;

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            valueCount++;
        end
    endtask

    // Outputs have settled by the falling edge
    always @(negedge clk) begin
        if (arstN) begin
            if (resultValid) begin
                // Flushed entries leave no result behind
                while (nextIdx < numEntries && !expResult[nextIdx]) begin
                    nextIdx++;
                end
                if (nextIdx >= numEntries) begin
                    $display("Error at %0t ns: extra result with tag %0d", $time, resultTag);
                    seqCount++;
                end else begin
                    checkValue("resultState", 32'(resultState), 32'(expState[nextIdx]));
                    checkValue("resultTag", 32'(resultTag), 32'(OpTag'(nextIdx)));
                    checkValue("replayValid", 32'(replayValid), 32'(expFlags[nextIdx][3]));
                    checkValue("replayMshr", 32'(replayMshr), 32'(expFlags[nextIdx][2]));
                    checkValue("orderViolation", 32'(orderViolation),
                               32'(expFlags[nextIdx][1]));
                    checkValue("fillReq", 32'(fillReq), 32'(expFlags[nextIdx][0]));
                    if (expFlags[nextIdx][0]) begin
                        checkValue("fillLine", 32'(fillLine), 32'(expLine[nextIdx]));
                    end
                    nextIdx++;
                    seenCount++;
                end
            end else if (replayValid || replayMshr || orderViolation || fillReq) begin
                $display("Error at %0t ns: replay, violation or fill request without a result",
                         $time);
                seqCount++;
            end
        end
    end

endmodule

`default_nettype wire

/* tbMemTagStage.sv */
//**********************************************************
// Memory tag-access stage testbench
// Drives a table of operations with stalls and flushes and
// hands the expected results to the checker
//**********************************************************

`timescale 1ns/100ps
`default_nettype none

`include "memTagStage_settings.svh"

module tbMemTagStage;
    import memTagPkg::*;

    localparam int Depth = 48;
    localparam int RandomOps = 12;

    logic      clk = 1'b0;
    logic      arstN, stall, flushAll, issueValid;
    MemOpType  issueOpType;
    EnvCode    issueEnvCode;
    AccessSize issueSize;
    MemAddr    issueAddr;
    OpTag      issueTag;
    logic      dcHit, forwarded, forwardMiss, conflict;
    logic      resultValid, replayValid, replayMshr, orderViolation, fillReq;
    ExecState  resultState;
    OpTag      resultTag;
    LineAddr   fillLine;

    // Stimulus table with lookTab packed as {dcHit, forwarded, forwardMiss, conflict}
    MemOpType   opTab [Depth];
    EnvCode     envTab [Depth];
    AccessSize  sizeTab [Depth];
    MemAddr     addrTab [Depth];
    logic [3:0] lookTab [Depth];
    int         gapTab [Depth];
    int         stallTab [Depth];
    logic       flushTab [Depth];
    // Expected results with expFlags packed as {replay, replayMshr, violation, fillReq}
    ExecState   expState [Depth];
    logic [3:0] expFlags [Depth];
    LineAddr    expLine [Depth];
    logic       expResult [Depth];

    int   numEntries = 0;
    int   expectedResults = 0;
    int   seed = 93415;
    logic tableReady = 1'b0;
    int   valueErrors, seqErrors, resultCount;

    always #10 clk = ~clk;

    memTagStage i_memTagStage (.*);

    tbMemTagChecker #(.Depth(Depth)) i_checker (
        .clk, .arstN, .resultValid, .resultState, .resultTag, .replayValid,
        .replayMshr, .orderViolation, .fillReq, .fillLine, .numEntries,
        .expResult, .expState, .expFlags, .expLine,
        .valueErrors, .seqErrors, .resultCount
    );

    task automatic addEntry(input MemOpType op, input AccessSize size, input MemAddr addr,
                            input logic [3:0] look, input ExecState state,
                            input logic [3:0] flags);
        opTab[numEntries]     = op;
        envTab[numEntries]    = EnvBreak;
        sizeTab[numEntries]   = size;
        addrTab[numEntries]   = addr;
        lookTab[numEntries]   = look;
        gapTab[numEntries]    = 0;
        stallTab[numEntries]  = 0;
        flushTab[numEntries]  = 1'b0;
        expState[numEntries]  = state;
        expFlags[numEntries]  = flags;
        expLine[numEntries]   = LineAddr'(addr / `MEMTAG_LINE_BYTES);
        expResult[numEntries] = 1'b1;
        numEntries++;
    endtask

    task automatic addEnv(input EnvCode code, input ExecState state);
        addEntry(OpEnv, SizeByte, '0, 4'b0000, state, 4'b0000);
        envTab[numEntries-1] = code;
    endtask

    // Applies to the entry added last
    task automatic setTiming(input int gap, input int stallCycles, input logic flush);
        gapTab[numEntries-1]    = gap;
        stallTab[numEntries-1]  = stallCycles;
        flushTab[numEntries-1]  = flush;
        expResult[numEntries-1] = !flush;
    endtask

    // Expected state of a load or store that does not miss
    function automatic ExecState expectedMemState(input MemOpType op, input AccessSize size,
                                                  input MemAddr addr, input logic [3:0] look);
        int       bytes;
        ExecState state;
        bytes = (size == SizeWord) ? 4 : ((size == SizeHalf) ? 2 : 1);
        if (op == OpLoad) begin
            state = (look[2] && look[1]) ? ExecRefetchThis : ExecSuccess;
        end else begin
            state = look[0] ? ExecRefetchNext : ExecSuccess;
        end
        if (state != ExecRefetchThis) begin
            if (addr >= `MEMTAG_LEGAL_LIMIT) begin
                state = (op == OpLoad) ? ExecFaultLoadViolation : ExecFaultStoreViolation;
            end else if ((addr % 32'(bytes)) != 0) begin
                state = (op == OpLoad) ? ExecFaultLoadMisaligned : ExecFaultStoreMisaligned;
            end
        end
        return state;
    endfunction

    // Loads here always hit or forward so the MSHR plays no part
    task automatic addRandomEntries(input int count);
        int         r;
        MemAddr     addr;
        MemOpType   op;
        AccessSize  size;
        logic [3:0] look;
        for (int i = 0; i < count; i++) begin
            r    = $random(seed);
            addr = $random(seed);
            op   = r[0] ? OpStore : OpLoad;
            size = r[1] ? SizeWord : (r[2] ? SizeHalf : SizeByte);
            look = (op == OpLoad) ? {1'b1, r[3], r[4], 1'b0} : {3'b000, r[5]};
            addEntry(op, size, addr, look, expectedMemState(op, size, addr, look),
                     {2'b00, (op == OpStore) && look[0], 1'b0});
            setTiming(int'(r[7:6]), 0, 1'b0);
        end
    endtask

    task automatic buildTable();
        // Forwarded, forwarded but missing, and cache hits
        addEntry(OpLoad, SizeWord, 32'h100, 4'b0100, ExecSuccess, 4'b0000);
        addEntry(OpLoad, SizeWord, 32'h104, 4'b0110, ExecRefetchThis, 4'b0000);
        addEntry(OpLoad, SizeHalf, 32'h202, 4'b1000, ExecSuccess, 4'b0000);
        addEntry(OpLoad, SizeByte, 32'h203, 4'b1000, ExecSuccess, 4'b0000);
        // First miss takes the MSHR, second finds it busy
        addEntry(OpLoad, SizeWord, 32'h4010, 4'b0000, ExecRefetchThis, 4'b1101);
        addEntry(OpLoad, SizeWord, 32'h5020, 4'b0000, ExecRefetchThis, 4'b1000);
        setTiming(`MEMTAG_FILL_LATENCY, 0, 1'b0);
        // Filled line read without dcHit, then the MSHR is free again
        addEntry(OpLoad, SizeWord, 32'h4018, 4'b0000, ExecSuccess, 4'b0000);
        addEntry(OpLoad, SizeWord, 32'h5020, 4'b0000, ExecRefetchThis, 4'b1101);
        setTiming(`MEMTAG_FILL_LATENCY + 2, 0, 1'b0);
        addEntry(OpStore, SizeWord, 32'h300, 4'b0000, ExecSuccess, 4'b0000);
        addEntry(OpStore, SizeWord, 32'h304, 4'b0001, ExecRefetchNext, 4'b0010);
        addEntry(OpFenceI, SizeByte, 32'h0, 4'b0000, ExecRefetchNext, 4'b0000);
        addEnv(EnvBreak, ExecTrapBreak);
        addEnv(EnvCall, ExecTrapCall);
        addEnv(EnvMret, ExecTrapMret);
        addEnv(EnvIllegal, ExecFaultIllegalInsn);
        // Fault checks with violation ahead of misalignment
        addEntry(OpLoad, SizeWord, 32'h102, 4'b1000, ExecFaultLoadMisaligned, 4'b0000);
        addEntry(OpLoad, SizeHalf, 32'h8000_0000, 4'b1000, ExecFaultLoadViolation, 4'b0000);
        addEntry(OpLoad, SizeWord, 32'h8000_0003, 4'b1000, ExecFaultLoadViolation, 4'b0000);
        addEntry(OpStore, SizeHalf, 32'h301, 4'b0000, ExecFaultStoreMisaligned, 4'b0000);
        addEntry(OpStore, SizeWord, 32'hffff_fff0, 4'b0001, ExecFaultStoreViolation, 4'b0010);
        addEntry(OpStore, SizeWord, 32'h306, 4'b0001, ExecFaultStoreMisaligned, 4'b0010);
        // Miss stays refetchThis and cannot take the filled MSHR
        addEntry(OpLoad, SizeWord, 32'h9000_0000, 4'b0000, ExecRefetchThis, 4'b1000);
        // Stalls and flushes where the flushed miss must not allocate
        addEntry(OpLoad, SizeWord, 32'h400, 4'b1000, ExecSuccess, 4'b0000);
        setTiming(0, 3, 1'b0);
        addEntry(OpLoad, SizeWord, 32'h5024, 4'b0000, ExecSuccess, 4'b0000);
        addEntry(OpLoad, SizeWord, 32'h6000, 4'b0000, ExecNone, 4'b0000);
        setTiming(0, 0, 1'b1);
        addEntry(OpLoad, SizeWord, 32'h7000, 4'b0000, ExecRefetchThis, 4'b1101);
        addEntry(OpStore, SizeWord, 32'h500, 4'b0001, ExecRefetchNext, 4'b0010);
        setTiming(1, 4, 1'b0);
        addEntry(OpStore, SizeWord, 32'h504, 4'b0001, ExecNone, 4'b0000);
        setTiming(0, 0, 1'b1);
        addRandomEntries(RandomOps);
        for (int i = 0; i < numEntries; i++) begin
            expectedResults += int'(expResult[i]);
        end
    endtask

    task automatic driveEntry(input int i);
        @(posedge clk);
        #1;
        issueValid   = 1'b1;
        issueOpType  = opTab[i];
        issueEnvCode = envTab[i];
        issueSize    = sizeTab[i];
        issueAddr    = addrTab[i];
        issueTag     = OpTag'(i);
        {dcHit, forwarded, forwardMiss, conflict} = lookTab[i];
        @(posedge clk);
        #1;
        issueValid = 1'b0;
        // Op now sits in the pipeline register
        flushAll   = flushTab[i];
        @(posedge clk);
        #1;
        flushAll = 1'b0;
        // Stall holds the result register with the op in it
        if (stallTab[i] != 0) begin
            stall = 1'b1;
            repeat (stallTab[i]) @(posedge clk);
            #1;
            stall = 1'b0;
        end
        repeat (gapTab[i]) @(posedge clk);
    endtask

    task automatic reportCounts();
        $display("Results checked: %0d of %0d, value errors: %0d, missing or extra results: %0d",
                 resultCount, expectedResults, valueErrors, seqErrors);
    endtask

    initial begin
        arstN        = 1'b0;
        stall        = 1'b0;
        flushAll     = 1'b0;
        issueValid   = 1'b0;
        issueOpType  = OpLoad;
        issueEnvCode = EnvBreak;
        issueSize    = SizeByte;
        issueAddr    = '0;
        issueTag     = '0;
        {dcHit, forwarded, forwardMiss, conflict} = 4'b0000;
        buildTable();
        tableReady = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        arstN = 1'b1;
        for (int i = 0; i < numEntries; i++) begin
            driveEntry(i);
        end
        wait (resultCount == expectedResults);
        // Leave room for a stray late result
        repeat (3) @(posedge clk);
        reportCounts();
        if (valueErrors == 0 && seqErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int budget;
        wait (tableReady);
        budget = 10 + 40;
        for (int i = 0; i < numEntries; i++) begin
            budget += 3 + stallTab[i] + gapTab[i];
        end
        #(budget * 20);
        $display("Timeout after %0d cycles, results are missing", budget);
        reportCounts();
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* memTagStage.f */
+incdir+.
memTagPkg.sv
memTagOpIf.sv
memTagPipeReg.sv
memTagFillTimer.sv
memTagMissFsm.sv
memTagResolve.sv
memTagStage.sv
tbMemTagChecker.sv
tbMemTagStage.sv

/* run.sh */
#!/bin/sh
# Build the tag-access stage testbench with Verilator and run it.
# The run passes only if the simulation prints its pass line.
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal --top-module tbMemTagStage -f memTagStage.f &&
./obj_dir/VtbMemTagStage | tee /dev/stderr | grep "Simulation PASSED" > /dev/null &&
echo "run.sh: simulation run passed" ||
{ echo "run.sh: simulation run failed"; exit 1; }
